//--- common/bpmPkg.sv
`default_nettype none

package bpmPkg;

    //////////////////////////////////////////////////////////////////////
    // Widths that carry a meaning

    typedef logic [31:0] csrData_t;
    typedef logic [3:0]  csrAddr_t;

    // Enough for 200 million clocks per heartbeat
    typedef logic [27:0] hbReload_t;
    typedef logic [23:0] markerReload_t;

    // Bit 0 is the software trigger, bits 6..1 the event triggers
    typedef logic [6:0]  triggerBus_t;

    //////////////////////////////////////////////////////////////////////
    // Register map

    // Indices not listed here read back as zero
    typedef enum csrAddr_t {
        SOFT_TRIGGER     = 4'd0,
        HEARTBEAT_RELOAD = 4'd1,
        FA_RELOAD        = 4'd2,
        SA_RELOAD        = 4'd3,
        SPI_MUX          = 4'd4,
        INTERLOCK        = 4'd5,
        BUILD_DATE       = 4'd6
    } csrIndex_e;

    typedef struct packed {
        logic     wr;
        csrAddr_t addr;
        csrData_t data;
    } csrReq_t;

    typedef struct packed {
        hbReload_t     hbReload;
        markerReload_t faReload;
        markerReload_t saReload;
    } timingCfg_t;

    typedef struct packed {
        logic faSynced;
        logic saSynced;
    } markerStatus_t;

    //////////////////////////////////////////////////////////////////////
    // Constants and reset values

    localparam csrData_t      FIRMWARE_BUILD_DATE = 32'h6A1C_5E03;
    // Heartbeat period of 100 clocks
    localparam hbReload_t     HB_RELOAD_DEFAULT   = 28'd98;
    localparam markerReload_t FA_RELOAD_DEFAULT   = 24'd9;
    localparam markerReload_t SA_RELOAD_DEFAULT   = 24'd99;
    localparam int            SOFT_STRETCH_CYCLES = 8;

    localparam timingCfg_t TIMING_CFG_DEFAULT = '{
        hbReload: HB_RELOAD_DEFAULT,
        faReload: FA_RELOAD_DEFAULT,
        saReload: SA_RELOAD_DEFAULT
    };

endpackage

`default_nettype wire

//--- timing/heartbeatGen.sv
`timescale 1ns/1ps
`default_nettype none

module heartbeatGen (
    input  wire logic              sysClk,
    input  wire logic              rst,
    input  wire bpmPkg::hbReload_t hbReload,
    output logic                   heartbeat
);

    // One spare bit on top, set for the single cycle after underflow
    logic [$bits(bpmPkg::hbReload_t):0] hbCount;

    assign heartbeat = hbCount[$bits(bpmPkg::hbReload_t)];

    //////////////////////////////////////////////////////////////////////
    // Down counter, period is hbReload+2
    // Reload is sampled only at the pulse
    always_ff @(posedge sysClk) begin
        if (rst) begin
            hbCount <= '0;
        end else if (heartbeat) begin
            hbCount <= {1'b0, hbReload};
        end else begin
            hbCount <= hbCount - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- timing/markerSync.sv
`timescale 1ns/1ps
`default_nettype none

module markerSync (
    input  wire logic                  sysClk,
    input  wire logic                  rst,
    input  wire logic                  heartbeat,
    input  wire bpmPkg::markerReload_t reload,
    output logic                       marker,
    output logic                       synced
);

    bpmPkg::markerReload_t divCount;
    bpmPkg::markerReload_t divNext;
    // Registered copy of divCount==0, kept low through reset
    logic                  atWrap;

    //////////////////////////////////////////////////////////////////////
    // Marker divider
    // Heartbeat forces a reload, which re-phases the divider
    assign marker = heartbeat | atWrap;

    always_comb begin
        if (marker) begin
            divNext = reload;
        end else begin
            divNext = divCount - 1'b1;
        end
    end

    always_ff @(posedge sysClk) begin
        if (rst) begin
            divCount <= '0;
            atWrap   <= 1'b0;
        end else begin
            divCount <= divNext;
            atWrap   <= (divNext == '0);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Phase check
    // Heartbeat landing on the wrap point means no correction was needed
    always_ff @(posedge sysClk) begin
        if (rst) begin
            synced <= 1'b0;
        end else if (heartbeat) begin
            synced <= atWrap;
        end
    end

endmodule

`default_nettype wire

//--- rtl/csrBank.sv
`timescale 1ns/1ps
`default_nettype none

module csrBank (
    input  wire logic                  sysClk,
    input  wire logic                  rst,
    input  wire bpmPkg::csrReq_t       csrReq,
    input  wire bpmPkg::markerStatus_t markerStatus,
    output bpmPkg::csrData_t           csrReadData,
    output bpmPkg::timingCfg_t         timingCfg,
    output logic                       softTrigger,
    output logic [1:0]                 clkSpiMuxSel,
    output logic                       interlockRelay
);

    bpmPkg::csrIndex_e reqIndex;
    bpmPkg::csrData_t  readNext;

    assign reqIndex = bpmPkg::csrIndex_e'(csrReq.addr);

    // Soft trigger is a pure strobe, nothing is stored
    assign softTrigger = csrReq.wr && (reqIndex == bpmPkg::SOFT_TRIGGER);

    //////////////////////////////////////////////////////////////////////
    // Write decode
    always_ff @(posedge sysClk) begin
        if (rst) begin
            timingCfg      <= bpmPkg::TIMING_CFG_DEFAULT;
            clkSpiMuxSel   <= 2'b00;
            interlockRelay <= 1'b0;
        end else if (csrReq.wr) begin
            case (reqIndex)
                bpmPkg::HEARTBEAT_RELOAD: begin
                    timingCfg.hbReload <= bpmPkg::hbReload_t'(csrReq.data);
                end
                bpmPkg::FA_RELOAD: begin
                    timingCfg.faReload <= bpmPkg::markerReload_t'(csrReq.data);
                end
                bpmPkg::SA_RELOAD: begin
                    timingCfg.saReload <= bpmPkg::markerReload_t'(csrReq.data);
                end
                bpmPkg::SPI_MUX: begin
                    clkSpiMuxSel <= csrReq.data[1:0];
                end
                bpmPkg::INTERLOCK: begin
                    interlockRelay <= csrReq.data[0];
                end
                default: begin
                    // Read-only or unused index
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Readback mux
    always_comb begin
        case (reqIndex)
            bpmPkg::HEARTBEAT_RELOAD: begin
                readNext = bpmPkg::csrData_t'(timingCfg.hbReload);
            end
            // Synced flag rides in the top bit
            bpmPkg::FA_RELOAD: begin
                readNext = {markerStatus.faSynced, 7'b0, timingCfg.faReload};
            end
            bpmPkg::SA_RELOAD: begin
                readNext = {markerStatus.saSynced, 7'b0, timingCfg.saReload};
            end
            bpmPkg::SPI_MUX: begin
                readNext = bpmPkg::csrData_t'(clkSpiMuxSel);
            end
            bpmPkg::INTERLOCK: begin
                readNext = bpmPkg::csrData_t'(interlockRelay);
            end
            bpmPkg::BUILD_DATE: begin
                readNext = bpmPkg::FIRMWARE_BUILD_DATE;
            end
            default: begin
                readNext = '0;
            end
        endcase
    end

    // One cycle read latency
    always_ff @(posedge sysClk) begin
        if (rst) begin
            csrReadData <= '0;
        end else begin
            csrReadData <= readNext;
        end
    end

endmodule

`default_nettype wire

//--- rtl/triggerCapture.sv
`timescale 1ns/1ps
`default_nettype none

module triggerCapture (
    input  wire logic           sysClk,
    input  wire logic           rst,
    input  wire logic           softTrigger,
    input  wire logic [5:0]     eventTriggers,
    output bpmPkg::triggerBus_t triggerStrobes
);

    logic [3:0]          stretchCount;
    logic                softLevel;
    bpmPkg::triggerBus_t syncMeta;
    bpmPkg::triggerBus_t syncOut;
    bpmPkg::triggerBus_t levelDelay;
    bpmPkg::triggerBus_t levelPrev;

    //////////////////////////////////////////////////////////////////////
    // Soft trigger stretch
    // A repeat write reloads the count so the level never drops
    assign softLevel = (stretchCount != 4'd0);

    always_ff @(posedge sysClk) begin
        if (rst) begin
            stretchCount <= 4'd0;
        end else if (softTrigger) begin
            stretchCount <= 4'(bpmPkg::SOFT_STRETCH_CYCLES);
        end else if (softLevel) begin
            stretchCount <= stretchCount - 4'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Synchronizer, delay and rising edge detect
    // Soft level shares the path so all strobes see the same latency
    always_ff @(posedge sysClk) begin
        if (rst) begin
            syncMeta       <= '0;
            syncOut        <= '0;
            levelDelay     <= '0;
            levelPrev      <= '0;
            triggerStrobes <= '0;
        end else begin
            syncMeta       <= {eventTriggers, softLevel};
            syncOut        <= syncMeta;
            levelDelay     <= syncOut;
            levelPrev      <= levelDelay;
            triggerStrobes <= levelDelay & ~levelPrev;
        end
    end

endmodule

`default_nettype wire

//--- rtl/bpmTriggerTop.sv
`timescale 1ns/1ps
`default_nettype none

module bpmTriggerTop (
    input  wire logic                  sysClk,
    input  wire logic                  rst,
    input  wire bpmPkg::csrReq_t       csrReq,
    input  wire logic [5:0]            eventTriggers,
    output bpmPkg::csrData_t           csrReadData,
    output bpmPkg::triggerBus_t        triggerStrobes,
    output logic                       heartbeat,
    output logic                       faMarker,
    output logic                       saMarker,
    output logic [1:0]                 clkSpiMuxSel,
    output logic                       interlockRelay
);

    bpmPkg::timingCfg_t    timingCfg;
    bpmPkg::markerStatus_t markerStatus;
    logic                  softTrigger;

    //////////////////////////////////////////////////////////////////////
    // Control and status registers
    csrBank i_csrBank (
        .sysClk        (sysClk),
        .rst           (rst),
        .csrReq        (csrReq),
        .markerStatus  (markerStatus),
        .csrReadData   (csrReadData),
        .timingCfg     (timingCfg),
        .softTrigger   (softTrigger),
        .clkSpiMuxSel  (clkSpiMuxSel),
        .interlockRelay(interlockRelay)
    );

    //////////////////////////////////////////////////////////////////////
    // Software and event triggers
    triggerCapture i_triggerCapture (
        .sysClk        (sysClk),
        .rst           (rst),
        .softTrigger   (softTrigger),
        .eventTriggers (eventTriggers),
        .triggerStrobes(triggerStrobes)
    );

    //////////////////////////////////////////////////////////////////////
    // Heartbeat and the acquisition markers locked to it
    heartbeatGen i_heartbeatGen (
        .sysClk   (sysClk),
        .rst      (rst),
        .hbReload (timingCfg.hbReload),
        .heartbeat(heartbeat)
    );

    markerSync faSync (
        .sysClk   (sysClk),
        .rst      (rst),
        .heartbeat(heartbeat),
        .reload   (timingCfg.faReload),
        .marker   (faMarker),
        .synced   (markerStatus.faSynced)
    );

    markerSync saSync (
        .sysClk   (sysClk),
        .rst      (rst),
        .heartbeat(heartbeat),
        .reload   (timingCfg.saReload),
        .marker   (saMarker),
        .synced   (markerStatus.saSynced)
    );

endmodule

`default_nettype wire

//--- testbench/bpmTrigger_sva.sv
`timescale 1ns/1ps
`default_nettype none

module bpmTriggerSva (
    input wire logic                sysClk,
    input wire logic                rst,
    input wire bpmPkg::csrData_t    csrReadData,
    input wire bpmPkg::triggerBus_t triggerStrobes,
    input wire logic                heartbeat,
    input wire logic                faMarker,
    input wire logic                saMarker,
    input wire logic [1:0]          clkSpiMuxSel,
    input wire logic                interlockRelay
);

    //////////////////////////////////////////////////////////////////////
    // Pulse shapes
    strobeSingle: assert property (@(posedge sysClk) disable iff (rst)
        (triggerStrobes & $past(triggerStrobes)) == '0)
        else $error("triggerStrobes bit high for two cycles");

    heartbeatSingle: assert property (@(posedge sysClk) disable iff (rst)
        heartbeat |=> !heartbeat)
        else $error("heartbeat high for two cycles");

    // Heartbeat always re-phases the FA divider
    faOnHeartbeat: assert property (@(posedge sysClk) disable iff (rst)
        heartbeat |-> faMarker)
        else $error("faMarker low during a heartbeat");

    // Outputs are registered, so check from the second reset cycle on
    quietInReset: assert property (@(posedge sysClk)
        rst && $past(rst) |-> csrReadData == '0 && triggerStrobes == '0 && !heartbeat
            && !faMarker && !saMarker && clkSpiMuxSel == '0 && !interlockRelay)
        else $error("output active during reset");

endmodule

bind bpmTriggerTop bpmTriggerSva i_bpmTriggerSva (
    .sysClk        (sysClk),
    .rst           (rst),
    .csrReadData   (csrReadData),
    .triggerStrobes(triggerStrobes),
    .heartbeat     (heartbeat),
    .faMarker      (faMarker),
    .saMarker      (saMarker),
    .clkSpiMuxSel  (clkSpiMuxSel),
    .interlockRelay(interlockRelay)
);

`default_nettype wire

//--- testbench/tbBpmTrigger.sv
`timescale 1ns/1ps
`default_nettype none

module tbBpmTrigger;

    typedef enum logic [2:0] {
        ACT_WRITE, ACT_READ, ACT_PINS, ACT_SOFT,
        ACT_EVENT, ACT_HB_PERIOD, ACT_MARKER, ACT_SYNCED
    } stepAction_e;

    // For reads the data field is a compare mask
    typedef struct packed {
        stepAction_e      action;
        bpmPkg::csrAddr_t addr;
        bpmPkg::csrData_t data;
        bpmPkg::csrData_t expected;
    } step_t;

    localparam int HB_WAIT_LIMIT    = 300;
    localparam int PULSE_WAIT_LIMIT = 40;

    logic                sysClk;
    logic                rst;
    bpmPkg::csrReq_t     csrReq;
    logic [5:0]          eventTriggers;
    bpmPkg::csrData_t    csrReadData;
    bpmPkg::triggerBus_t triggerStrobes;
    logic                heartbeat;
    logic                faMarker;
    logic                saMarker;
    logic [1:0]          clkSpiMuxSel;
    logic                interlockRelay;

    step_t steps[$];
    int    strobeCount[7];
    int    mismatchCount;
    int    timeoutCount;

    bpmTriggerTop i_bpmTriggerTop (
        .sysClk        (sysClk),
        .rst           (rst),
        .csrReq        (csrReq),
        .eventTriggers (eventTriggers),
        .csrReadData   (csrReadData),
        .triggerStrobes(triggerStrobes),
        .heartbeat     (heartbeat),
        .faMarker      (faMarker),
        .saMarker      (saMarker),
        .clkSpiMuxSel  (clkSpiMuxSel),
        .interlockRelay(interlockRelay)
    );

    always #4 sysClk = ~sysClk;

    //////////////////////////////////////////////////////////////////////
    // Cycle stepping and compare tasks

    // Every wait goes through here so strobe counts never miss a pulse
    task automatic stepCycle();
        @(negedge sysClk);
        for (int i = 0; i < 7; i++) begin
            if (!rst && triggerStrobes[i]) begin
                strobeCount[i]++;
            end
        end
    endtask

    task automatic checkData(input string name, input bpmPkg::csrData_t expected,
                             input bpmPkg::csrData_t actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            mismatchCount++;
        end
    endtask

    task automatic checkTrigger(input string name, input bpmPkg::triggerBus_t expected,
                                input bpmPkg::triggerBus_t actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            mismatchCount++;
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            mismatchCount++;
        end
    endtask

    task automatic writeCsr(input bpmPkg::csrAddr_t addr, input bpmPkg::csrData_t data);
        csrReq.wr   = 1'b1;
        csrReq.addr = addr;
        csrReq.data = data;
        stepCycle();
        csrReq.wr = 1'b0;
    endtask

    task automatic readCsr(input bpmPkg::csrAddr_t addr, output bpmPkg::csrData_t data);
        csrReq.addr = addr;
        stepCycle();
        data = csrReadData;
    endtask

    task automatic waitHeartbeat();
        int waited;
        waited = 0;
        do begin
            stepCycle();
            waited++;
        end while (!heartbeat && waited < HB_WAIT_LIMIT);
        if (!heartbeat) begin
            $display("Timed out waiting for a heartbeat pulse");
            timeoutCount++;
        end
    endtask

    // Cycles from a heartbeat to the next heartbeat, FA marker or SA marker
    task automatic measureSpacing(input bpmPkg::csrAddr_t source, input int expected);
        int    spacing;
        logic  seen;
        string name;
        spacing = 0;
        case (source)
            bpmPkg::FA_RELOAD: name = "faMarker spacing";
            bpmPkg::SA_RELOAD: name = "saMarker spacing";
            default:           name = "heartbeat spacing";
        endcase
        waitHeartbeat();
        do begin
            stepCycle();
            spacing++;
            case (source)
                bpmPkg::FA_RELOAD: seen = faMarker;
                bpmPkg::SA_RELOAD: seen = saMarker;
                default:           seen = heartbeat;
            endcase
        end while (!seen && spacing < HB_WAIT_LIMIT);
        if (!seen) begin
            $display("No second pulse arrived while measuring %s", name);
            timeoutCount++;
        end else begin
            checkData(name, bpmPkg::csrData_t'(expected), bpmPkg::csrData_t'(spacing));
        end
    endtask

    task automatic waitStrobe(input int bitIndex, input int baseCount);
        int waited;
        waited = 0;
        while (strobeCount[bitIndex] <= baseCount && waited < PULSE_WAIT_LIMIT) begin
            stepCycle();
            waited++;
        end
        if (strobeCount[bitIndex] <= baseCount) begin
            $display("No strobe appeared on triggerStrobes bit %0d", bitIndex);
            timeoutCount++;
        end
    endtask

    function automatic bpmPkg::triggerBus_t strobesSince(input int base[7], input int atLeast);
        bpmPkg::triggerBus_t mask;
        for (int i = 0; i < 7; i++) begin
            mask[i] = ((strobeCount[i] - base[i]) >= atLeast);
        end
        return mask;
    endfunction

    // Soft trigger (one or two writes) or one event level raised, held and dropped
    task automatic runTrigger(input step_t step);
        int base[7];
        base = strobeCount;
        if (step.action == ACT_SOFT) begin
            writeCsr(bpmPkg::SOFT_TRIGGER, '0);
            if (step.data > 1) begin
                repeat (3) stepCycle();
                writeCsr(bpmPkg::SOFT_TRIGGER, '0);
            end
            waitStrobe(0, base[0]);
        end else begin
            eventTriggers[step.addr] = 1'b1;
            waitStrobe(int'(step.addr) + 1, base[int'(step.addr) + 1]);
            repeat (20) stepCycle();
            eventTriggers[step.addr] = 1'b0;
        end
        repeat (20) stepCycle();
        checkTrigger("triggerStrobes", bpmPkg::triggerBus_t'(step.expected),
                     strobesSince(base, 1));
        checkTrigger("repeated triggerStrobes", '0, strobesSince(base, 2));
    endtask

    function automatic void addStep(input stepAction_e action, input bpmPkg::csrAddr_t addr,
                                    input bpmPkg::csrData_t data,
                                    input bpmPkg::csrData_t expected);
        steps.push_back('{action, addr, data, expected});
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus table and main loop
    initial begin
        bpmPkg::csrData_t rdata;
        bpmPkg::csrData_t value;
        bpmPkg::csrData_t pinValue;
        int unsigned      eventBit;
        step_t            step;

        void'($urandom(81570));
        sysClk        = 1'b0;
        rst           = 1'b1;
        csrReq        = '0;
        eventTriggers = '0;
        mismatchCount = 0;
        timeoutCount  = 0;
        foreach (strobeCount[i]) begin
            strobeCount[i] = 0;
        end

        addStep(ACT_READ, bpmPkg::HEARTBEAT_RELOAD, '1, 32'(bpmPkg::HB_RELOAD_DEFAULT));
        addStep(ACT_READ, bpmPkg::FA_RELOAD, 32'h7FFF_FFFF, 32'(bpmPkg::FA_RELOAD_DEFAULT));
        // Timing first, before random reloads make the heartbeat slow
        addStep(ACT_WRITE, bpmPkg::HEARTBEAT_RELOAD, 32'd22, '0);
        addStep(ACT_HB_PERIOD, '0, '0, 32'd24);
        addStep(ACT_WRITE, bpmPkg::FA_RELOAD, 32'd5, '0);
        addStep(ACT_MARKER, bpmPkg::FA_RELOAD, '0, 32'd6);
        addStep(ACT_SYNCED, bpmPkg::FA_RELOAD, '0, 32'd1);
        addStep(ACT_WRITE, bpmPkg::FA_RELOAD, 32'd6, '0);
        addStep(ACT_MARKER, bpmPkg::FA_RELOAD, '0, 32'd7);
        addStep(ACT_SYNCED, bpmPkg::FA_RELOAD, '0, 32'd0);
        // SA divider period 4 fits the heartbeat period 24
        addStep(ACT_WRITE, bpmPkg::SA_RELOAD, 32'd3, '0);
        addStep(ACT_MARKER, bpmPkg::SA_RELOAD, '0, 32'd4);
        addStep(ACT_SYNCED, bpmPkg::SA_RELOAD, '0, 32'd1);
        addStep(ACT_SOFT, '0, 32'd1, 32'h01);
        addStep(ACT_SOFT, '0, 32'd2, 32'h01);
        repeat (2) begin
            eventBit = $urandom % 6;
            addStep(ACT_EVENT, bpmPkg::csrAddr_t'(eventBit), '0, 32'd1 << (eventBit + 1));
        end
        // Random readback, synced bit left out of the reload compares
        rdata = $urandom;
        addStep(ACT_WRITE, bpmPkg::HEARTBEAT_RELOAD, rdata, '0);
        addStep(ACT_READ, bpmPkg::HEARTBEAT_RELOAD, '1, rdata & 32'h0FFF_FFFF);
        rdata = $urandom;
        addStep(ACT_WRITE, bpmPkg::FA_RELOAD, rdata, '0);
        addStep(ACT_READ, bpmPkg::FA_RELOAD, 32'h7FFF_FFFF, rdata & 32'h00FF_FFFF);
        rdata = $urandom;
        addStep(ACT_WRITE, bpmPkg::SA_RELOAD, rdata, '0);
        addStep(ACT_READ, bpmPkg::SA_RELOAD, 32'h7FFF_FFFF, rdata & 32'h00FF_FFFF);
        rdata = $urandom;
        pinValue = rdata & 32'h3;
        addStep(ACT_WRITE, bpmPkg::SPI_MUX, rdata, '0);
        addStep(ACT_READ, bpmPkg::SPI_MUX, '1, rdata & 32'h3);
        rdata = $urandom;
        pinValue = pinValue | ((rdata & 32'h1) << 2);
        addStep(ACT_WRITE, bpmPkg::INTERLOCK, rdata, '0);
        addStep(ACT_READ, bpmPkg::INTERLOCK, '1, rdata & 32'h1);
        addStep(ACT_PINS, '0, '0, pinValue);
        addStep(ACT_READ, bpmPkg::BUILD_DATE, '1, bpmPkg::FIRMWARE_BUILD_DATE);
        addStep(ACT_READ, bpmPkg::SOFT_TRIGGER, '1, '0);
        addStep(ACT_READ, bpmPkg::csrAddr_t'(7 + $urandom % 9), '1, '0);

        repeat (2) stepCycle();
        rst = 1'b0;

        foreach (steps[n]) begin
            step = steps[n];
            case (step.action)
                ACT_WRITE: writeCsr(step.addr, step.data);
                ACT_READ: begin
                    readCsr(step.addr, value);
                    checkData($sformatf("csrReadData[%0d]", step.addr), step.expected,
                              value & step.data);
                end
                ACT_PINS: begin
                    checkData("clkSpiMuxSel", step.expected & 32'h3,
                              bpmPkg::csrData_t'(clkSpiMuxSel));
                    checkBit("interlockRelay", step.expected[2], interlockRelay);
                end
                ACT_SOFT, ACT_EVENT: runTrigger(step);
                ACT_HB_PERIOD: begin
                    // Let the new reload land at one pulse first
                    waitHeartbeat();
                    measureSpacing(bpmPkg::HEARTBEAT_RELOAD, int'(step.expected));
                end
                ACT_MARKER: measureSpacing(step.addr, int'(step.expected));
                ACT_SYNCED: begin
                    repeat (2) waitHeartbeat();
                    stepCycle();
                    readCsr(step.addr, value);
                    checkBit($sformatf("csrReadData[%0d] synced bit", step.addr),
                             step.expected[0], value[31]);
                end
                default: begin
                end
            endcase
        end

        $display("Run finished with %0d mismatches and %0d timeouts", mismatchCount,
                 timeoutCount);
        if (mismatchCount == 0 && timeoutCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
common/bpmPkg.sv
timing/heartbeatGen.sv
timing/markerSync.sv
rtl/csrBank.sv
rtl/triggerCapture.sv
rtl/bpmTriggerTop.sv
testbench/bpmTrigger_sva.sv
testbench/tbBpmTrigger.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tbBpmTrigger
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
